// ==== snes_mem_arbiter.f ====
+incdir+include
source/snes_mem_pkg.sv
source/mem_access_if.sv
source/snes_bus_sync.sv
source/slot_sequencer.sv
source/snes_addr_map.sv
source/mcu_handshake.sv
source/psram_ctrl.sv
source/snes_mem_arbiter.sv
tests/psram_model.sv
tests/tb_snes_mem_arbiter.sv

// ==== Bender.yml ====
package:
  name: snes_mem_arbiter

sources:
  - include_dirs:
      - include
    files:
      - source/snes_mem_pkg.sv
      - source/mem_access_if.sv
      - source/snes_bus_sync.sv
      - source/slot_sequencer.sv
      - source/snes_addr_map.sv
      - source/mcu_handshake.sv
      - source/psram_ctrl.sv
      - source/snes_mem_arbiter.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/psram_model.sv
      - tests/tb_snes_mem_arbiter.sv

// ==== tests/tb_snes_mem_arbiter.sv ====
`timescale 1ns/1ps
`include "snes_mem_consts.svh"

module tb_snes_mem_arbiter;

  localparam int SNES_CYCLES = 600;

  logic                    CLK2;
  logic                    reset;
  logic                    snes_cpu_clk;
  logic                    snes_rd_n;
  logic                    snes_wr_n;
  logic [23:0]             snes_addr;
  snes_mem_pkg::byte_t     snes_wdata;
  snes_mem_pkg::byte_t     snes_rdata;
  logic                    snes_data_drive;
  snes_mem_pkg::mapper_e   mapper;
  snes_mem_pkg::mem_addr_t rom_mask;
  snes_mem_pkg::mem_addr_t saveram_mask;
  logic                    mcu_req;
  logic                    mcu_write;
  snes_mem_pkg::mem_addr_t mcu_addr;
  snes_mem_pkg::byte_t     mcu_wdata;
  snes_mem_pkg::byte_t     mcu_rdata;
  logic                    mcu_ack;
  logic [22:0]             rom_addr;
  logic [15:0]             rom_wdata;
  logic [15:0]             rom_rdata;
  logic                    rom_oe_n;
  logic                    rom_we_n;
  logic                    rom_bhe_n;
  logic                    rom_ble_n;

  integer seed = 30;
  int     errors = 0;
  logic   mcu_done;

  // Expected bytes by address
  // Absent entries still hold the fill pattern
  snes_mem_pkg::byte_t     ref_mem [snes_mem_pkg::mem_addr_t];
  snes_mem_pkg::mem_addr_t readback [$];

  snes_mem_arbiter dut (
    .CLK2 (CLK2), .reset (reset),
    .snes_cpu_clk (snes_cpu_clk), .snes_rd_n (snes_rd_n), .snes_wr_n (snes_wr_n),
    .snes_addr (snes_addr), .snes_wdata (snes_wdata), .snes_rdata (snes_rdata),
    .snes_data_drive (snes_data_drive),
    .mapper (mapper), .rom_mask (rom_mask), .saveram_mask (saveram_mask),
    .mcu_req (mcu_req), .mcu_write (mcu_write), .mcu_addr (mcu_addr),
    .mcu_wdata (mcu_wdata), .mcu_rdata (mcu_rdata), .mcu_ack (mcu_ack),
    .rom_addr (rom_addr), .rom_wdata (rom_wdata), .rom_rdata (rom_rdata),
    .rom_oe_n (rom_oe_n), .rom_we_n (rom_we_n),
    .rom_bhe_n (rom_bhe_n), .rom_ble_n (rom_ble_n)
  );

  psram_model u_psram (
    .CLK2 (CLK2), .addr (rom_addr), .wdata (rom_wdata), .rdata (rom_rdata),
    .oe_n (rom_oe_n), .we_n (rom_we_n), .bhe_n (rom_bhe_n), .ble_n (rom_ble_n)
  );

  always #10 CLK2 = ~CLK2;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic snes_mem_pkg::byte_t ref_read(input snes_mem_pkg::mem_addr_t a);
    logic [22:0] w;
    logic [15:0] f;
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    w = a[23:1];
    f = w[15:0] ^ w[22:7];
    return a[0] ? f[15:8] : f[7:0];
  endfunction

  // 0 unmapped, 1 ROM, 2 save RAM
  function automatic int map_ref(input logic [23:0] a, input snes_mem_pkg::mapper_e m,
                                 output snes_mem_pkg::mem_addr_t pa);
    logic [7:0] bank;
    bank = a[23:16];
    pa   = '0;
    if (m == snes_mem_pkg::hirom) begin
      if (bank[6:5] == 2'b01 && a[15:0] >= 16'h6000 && a[15:0] <= 16'h7FFF) begin
        pa = `SAVERAM_BASE + (((24'(bank[4:0]) * 24'h2000) + 24'(a[12:0])) & saveram_mask);
        return 2;
      end
      if (bank[6] || a[15]) begin
        pa = a & rom_mask;
        return 1;
      end
    end else begin
      if (bank[6:4] == 3'b111 && !a[15]) begin
        pa = `SAVERAM_BASE + (((24'(bank[3:0]) * 24'h8000) + 24'(a[14:0])) & saveram_mask);
        return 2;
      end
      if (a[15]) begin
        pa = 24'({bank[6:0], a[14:0]}) & rom_mask;
        return 1;
      end
    end
    return 0;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_byte(input string name, input snes_mem_pkg::byte_t got,
                            input snes_mem_pkg::byte_t exp);
    if (got !== exp) begin
      $display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input snes_mem_pkg::mem_addr_t got,
                            input snes_mem_pkg::mem_addr_t exp);
    if (got !== exp) begin
      $display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail time=%0t %s got=%b expected=%b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Strobe sanity over the whole run
  always @(posedge CLK2) begin
    if (!reset && !rom_oe_n && !rom_we_n) begin
      $display("PSRAM read and write strobes were active together at %0t", $time);
      errors++;
    end
    if (!reset && !rom_we_n && (rom_bhe_n == rom_ble_n)) begin
      $display("PSRAM write at %0t did not enable exactly one byte lane", $time);
      errors++;
    end
  end

  ////////////////////
  // SNES bus driver
  ////////////////////

  task automatic snes_cycle(input logic [23:0] a, input snes_mem_pkg::mapper_e m,
                            input logic is_write, input snes_mem_pkg::byte_t wd);
    int                      period;
    int                      cls;
    snes_mem_pkg::mem_addr_t pa;
    logic                    drive_seen;
    logic                    we_seen;
    period     = 16 + ({$random(seed)} % 9);
    cls        = map_ref(a, m, pa);
    drive_seen = 1'b0;
    we_seen    = 1'b0;
    @(posedge CLK2);
    snes_addr    <= a;
    mapper       <= m;
    snes_rd_n    <= is_write;
    snes_wr_n    <= ~is_write;
    snes_wdata   <= wd;
    snes_cpu_clk <= 1'b1;
    if (is_write && cls == 2) begin
      ref_mem[pa] = wd;
    end
    if (is_write && cls != 0) begin
      readback.push_back(pa);
    end
    for (int i = 0; i < period; i++) begin
      @(posedge CLK2);
      if (snes_data_drive) begin
        drive_seen = 1'b1;
      end
      // SNES phase covers steps 4 to 9
      if (i >= 4 && i <= 9 && !rom_we_n) begin
        we_seen = 1'b1;
      end
      // SNES address on the pins during slot 1
      if (i == 5 && cls != 0) begin
        check_addr("rom_addr", {rom_addr, 1'b0}, {pa[23:1], 1'b0});
      end
      if (i == period / 2 - 1) begin
        snes_cpu_clk <= 1'b0;
      end
    end
    check_bit("snes_data_drive", drive_seen, cls != 0 && !is_write);
    check_bit("rom_we_n active", we_seen, is_write && cls == 2);
    if (cls != 0 && !is_write) begin
      check_byte("snes_rdata", snes_rdata, ref_read(pa));
    end
  endtask

  // Keeps the CPU clock running while the MCU side works
  task automatic snes_background(input int mode, input int min_cycles);
    int          n;
    logic [23:0] a;
    n = 0;
    while (!mcu_done || n < min_cycles) begin
      a = $random(seed);
      if (mode == 0) begin
        snes_cycle({8'h00, 1'b0, a[14:0]}, snes_mem_pkg::hirom, 1'b0, 8'h00);
      end else begin
        snes_cycle({a[23:16], 1'b1, a[14:0]}, snes_mem_pkg::lorom, 1'b0, 8'h00);
      end
      n++;
    end
  endtask

  ////////////////////
  // MCU master
  ////////////////////

  task automatic mcu_access(input logic is_write, input snes_mem_pkg::mem_addr_t a,
                            input snes_mem_pkg::byte_t wd, output snes_mem_pkg::byte_t rd);
    int waits;
    check_bit("mcu_ack", mcu_ack, 1'b0);
    @(posedge CLK2);
    mcu_req   <= 1'b1;
    mcu_write <= is_write;
    mcu_addr  <= a;
    mcu_wdata <= wd;
    if (is_write) begin
      ref_mem[a] = wd;
    end
    waits = 0;
    do begin
      @(posedge CLK2);
      waits++;
    end while (!mcu_ack && waits < 400);
    if (!mcu_ack) begin
      $display("mcu_ack never rose for the access at %h", a);
      errors++;
    end
    rd = mcu_rdata;
    mcu_req <= 1'b0;
    waits = 0;
    do begin
      @(posedge CLK2);
      waits++;
    end while (mcu_ack && waits < 400);
    if (mcu_ack) begin
      $display("mcu_ack stayed high after mcu_req dropped at %h", a);
      errors++;
    end
  endtask

  task automatic mcu_read_check(input snes_mem_pkg::mem_addr_t a);
    snes_mem_pkg::byte_t rd;
    mcu_access(1'b0, a, 8'h00, rd);
    check_byte("mcu_rdata", rd, ref_read(a));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    snes_mem_pkg::mem_addr_t addrs [$];
    snes_mem_pkg::mem_addr_t a;
    snes_mem_pkg::byte_t     rd;
    logic [31:0]             r;
    int                      k;
    CLK2 = 1'b0;
    reset = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_addr = '0;
    snes_wdata = '0;
    mapper = snes_mem_pkg::hirom;
    rom_mask = 24'h3FFFFF;
    saveram_mask = 24'h01FFFF;
    mcu_req = 1'b0;
    mcu_write = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    mcu_done = 1'b0;
    repeat (4) @(posedge CLK2);
    reset <= 1'b0;
    @(posedge CLK2);
    check_bit("rom_oe_n", rom_oe_n, 1'b1);
    check_bit("rom_we_n", rom_we_n, 1'b1);
    check_bit("mcu_ack", mcu_ack, 1'b0);
    check_bit("snes_data_drive", snes_data_drive, 1'b0);

    // MCU writes then reads with the neighbour byte checked too
    fork
      snes_background(0, 1);
      begin
        repeat (20) begin
          a = $random(seed);
          r = $random(seed);
          mcu_access(1'b1, a, r[7:0], rd);
          addrs.push_back(a);
        end
        foreach (addrs[i]) begin
          mcu_read_check(addrs[i]);
          mcu_read_check(addrs[i] ^ 24'h1);
        end
        mcu_done = 1'b1;
      end
    join

    // Random SNES traffic over all address classes
    repeat (60) begin
      a = $random(seed);
      r = $random(seed);
      k = {$random(seed)} % 4;
      case (k)
        0: begin
          if (r[0]) a[15] = 1'b1;
          else a[22] = 1'b1;
        end
        1: begin
          if (r[0]) begin
            a[22:20] = 3'b111;
            a[15]    = 1'b0;
          end else begin
            a[22:21] = 2'b01;
            a[15:13] = 3'b011;
          end
        end
        3: begin
          a[22:20] = 3'b000;
          a[15]    = 1'b0;
        end
        default: begin
        end
      endcase
      snes_cycle(a, r[0] ? snes_mem_pkg::lorom : snes_mem_pkg::hirom, r[1], r[15:8]);
    end

    // MCU readback of every SNES write target
    mcu_done = 1'b0;
    fork
      snes_background(0, 1);
      begin
        while (readback.size() > 0) begin
          mcu_read_check(readback.pop_front());
        end
        mcu_done = 1'b1;
      end
    join

    // Mixed traffic with the MCU kept above the ROM image
    mcu_done = 1'b0;
    fork
      snes_background(1, 20);
      begin
        repeat (15) begin
          r = $random(seed);
          a = {2'b10, r[21:0]};
          mcu_access(1'b1, a, r[31:24], rd);
          mcu_read_check(a);
          mcu_read_check(a ^ 24'h1);
        end
        mcu_done = 1'b1;
      end
    join

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized for the longest SNES cycle
  initial begin
    #(SNES_CYCLES * 24 * 20 * 3 / 2);
    $display("Watchdog expired before the test sequence finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== tests/psram_model.sv ====
`timescale 1ns/1ps

module psram_model (
  input  logic        CLK2,
  input  logic [22:0] addr,
  input  logic [15:0] wdata,
  output logic [15:0] rdata,
  input  logic        oe_n,
  input  logic        we_n,
  input  logic        bhe_n,
  input  logic        ble_n
);

  // Sparse word store, unwritten words read as a fill pattern
  logic [15:0] mem [logic [22:0]];

  function automatic logic [15:0] word_at(input logic [22:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    // Fill depends on every address bit
    return a[15:0] ^ a[22:7];
  endfunction

  always_comb begin
    rdata = oe_n ? 16'h0000 : word_at(addr);
  end

  // Write sampled on the clock while the write strobe is low
  always @(posedge CLK2) begin : write_port
    logic [15:0] w;
    if (!we_n) begin
      w = word_at(addr);
      if (!ble_n) begin
        w[7:0] = wdata[7:0];
      end
      if (!bhe_n) begin
        w[15:8] = wdata[15:8];
      end
      mem[addr] = w;
    end
  end

endmodule

// ==== source/snes_mem_arbiter.sv ====
`timescale 1ns/1ps

module snes_mem_arbiter (
  input  logic                    CLK2,
  input  logic                    reset,

  // SNES cartridge bus
  input  logic                    snes_cpu_clk,
  input  logic                    snes_rd_n,
  input  logic                    snes_wr_n,
  input  logic [23:0]             snes_addr,
  input  snes_mem_pkg::byte_t     snes_wdata,
  output snes_mem_pkg::byte_t     snes_rdata,
  output logic                    snes_data_drive,

  // Mapping setup
  input  snes_mem_pkg::mapper_e   mapper,
  input  snes_mem_pkg::mem_addr_t rom_mask,
  input  snes_mem_pkg::mem_addr_t saveram_mask,

  // Microcontroller
  input  logic                    mcu_req,
  input  logic                    mcu_write,
  input  snes_mem_pkg::mem_addr_t mcu_addr,
  input  snes_mem_pkg::byte_t     mcu_wdata,
  output snes_mem_pkg::byte_t     mcu_rdata,
  output logic                    mcu_ack,

  // PSRAM
  output logic [22:0]             rom_addr,
  output logic [15:0]             rom_wdata,
  input  logic [15:0]             rom_rdata,
  output logic                    rom_oe_n,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n
);

  logic                cycle_start;
  logic                snes_write;
  snes_mem_pkg::slot_t slot;

  mem_access_if snes_acc ();
  mem_access_if mcu_acc ();

  snes_bus_sync u_bus_sync (
    .CLK2         (CLK2),
    .reset        (reset),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .cycle_start  (cycle_start),
    .snes_write   (snes_write)
  );

  slot_sequencer u_slot_seq (
    .CLK2        (CLK2),
    .reset       (reset),
    .cycle_start (cycle_start),
    .slot        (slot)
  );

  snes_addr_map u_addr_map (
    .CLK2            (CLK2),
    .reset           (reset),
    .cycle_start     (cycle_start),
    .snes_write      (snes_write),
    .snes_addr       (snes_addr),
    .mapper          (mapper),
    .rom_mask        (rom_mask),
    .saveram_mask    (saveram_mask),
    .acc             (snes_acc.initiator),
    .snes_wdata      (snes_wdata),
    .snes_rdata      (snes_rdata),
    .snes_data_drive (snes_data_drive),
    .slot            (slot)
  );

  mcu_handshake u_mcu_hs (
    .CLK2      (CLK2),
    .reset     (reset),
    .mcu_req   (mcu_req),
    .mcu_write (mcu_write),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_rdata (mcu_rdata),
    .mcu_ack   (mcu_ack),
    .slot      (slot),
    .acc       (mcu_acc.initiator)
  );

  psram_ctrl u_psram_ctrl (
    .CLK2      (CLK2),
    .reset     (reset),
    .slot      (slot),
    .snes_acc  (snes_acc.target),
    .mcu_acc   (mcu_acc.target),
    .rom_addr  (rom_addr),
    .rom_wdata (rom_wdata),
    .rom_rdata (rom_rdata),
    .rom_oe_n  (rom_oe_n),
    .rom_we_n  (rom_we_n),
    .rom_bhe_n (rom_bhe_n),
    .rom_ble_n (rom_ble_n)
  );

endmodule

// ==== source/psram_ctrl.sv ====
`timescale 1ns/1ps
`include "snes_mem_consts.svh"

module psram_ctrl (
  input  logic                CLK2,
  input  logic                reset,
  input  snes_mem_pkg::slot_t slot,
  mem_access_if.target        snes_acc,
  mem_access_if.target        mcu_acc,
  output logic [22:0]         rom_addr,
  output logic [15:0]         rom_wdata,
  input  logic [15:0]         rom_rdata,
  output logic                rom_oe_n,
  output logic                rom_we_n,
  output logic                rom_bhe_n,
  output logic                rom_ble_n
);

  logic                    snes_phase;
  logic                    mcu_phase;
  logic                    active;
  logic                    wr_window;
  logic                    rd_active;
  logic                    wr_active;
  logic                    sel_write;
  snes_mem_pkg::mem_addr_t sel_addr;
  snes_mem_pkg::byte_t     sel_wdata;

  // Byte from the lane given by address bit 0
  function automatic snes_mem_pkg::byte_t lane_byte(input logic [15:0] word,
                                                    input logic odd);
    return odd ? word[15:8] : word[7:0];
  endfunction

  ////////////////////
  // Phase select
  ////////////////////

  always_comb begin
    snes_phase = (slot <= snes_mem_pkg::slot_t'(`SNES_LAST_SLOT));
    mcu_phase  = (slot >= snes_mem_pkg::slot_t'(`MCU_FIRST_SLOT))
               && (slot <= snes_mem_pkg::slot_t'(`SLOT_LAST));
    if (snes_phase) begin
      sel_addr  = snes_acc.addr;
      sel_wdata = snes_acc.wdata;
      sel_write = snes_acc.write;
      active    = snes_acc.valid;
      // SNES write strobe waits for the bus data
      wr_window = (slot >= snes_mem_pkg::slot_t'(`SNES_WDATA_SLOT));
    end else begin
      sel_addr  = mcu_acc.addr;
      sel_wdata = mcu_acc.wdata;
      sel_write = mcu_acc.write;
      active    = mcu_phase & mcu_acc.valid;
      wr_window = 1'b1;
    end
    rd_active = active & ~sel_write;
    wr_active = active & sel_write & wr_window;
  end

  ////////////////////
  // PSRAM pins
  ////////////////////

  assign rom_addr  = sel_addr[23:1];
  assign rom_wdata = {sel_wdata, sel_wdata};
  assign rom_oe_n  = ~rd_active;
  assign rom_we_n  = ~wr_active;

  // Reads open both lanes, writes only the addressed one
  assign rom_ble_n = ~(rd_active | (wr_active & ~sel_addr[0]));
  assign rom_bhe_n = ~(rd_active | (wr_active & sel_addr[0]));

  // Read data capture at the end of each phase's capture slot
  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_acc.rdata <= '0;
      mcu_acc.rdata  <= '0;
    end else begin
      if (slot == snes_mem_pkg::slot_t'(`SNES_CAPTURE_SLOT)
          && snes_acc.valid && !snes_acc.write) begin
        snes_acc.rdata <= lane_byte(rom_rdata, snes_acc.addr[0]);
      end
      if (slot == snes_mem_pkg::slot_t'(`MCU_CAPTURE_SLOT)
          && mcu_acc.valid && !mcu_acc.write) begin
        mcu_acc.rdata <= lane_byte(rom_rdata, mcu_acc.addr[0]);
      end
    end
  end

endmodule

// ==== source/mcu_handshake.sv ====
`timescale 1ns/1ps
`include "snes_mem_consts.svh"

module mcu_handshake (
  input  logic                    CLK2,
  input  logic                    reset,
  input  logic                    mcu_req,
  input  logic                    mcu_write,
  input  snes_mem_pkg::mem_addr_t mcu_addr,
  input  snes_mem_pkg::byte_t     mcu_wdata,
  output snes_mem_pkg::byte_t     mcu_rdata,
  output logic                    mcu_ack,
  input  snes_mem_pkg::slot_t     slot,
  mem_access_if.initiator         acc
);

  logic                    grant;
  logic                    valid_q;
  logic                    write_q;
  snes_mem_pkg::mem_addr_t addr_q;
  snes_mem_pkg::byte_t     wdata_q;

  // New request only after the previous ack returned to zero
  assign grant = (slot == snes_mem_pkg::slot_t'(`MCU_FIRST_SLOT - 1))
               & mcu_req & ~mcu_ack & ~valid_q;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      valid_q <= 1'b0;
      mcu_ack <= 1'b0;
    end else begin
      if (grant) begin
        valid_q <= 1'b1;
      end else if (valid_q && slot == snes_mem_pkg::slot_t'(`MCU_CAPTURE_SLOT)) begin
        valid_q <= 1'b0;
        mcu_ack <= 1'b1;
      end
      // Return to zero once the MCU lets go
      if (mcu_ack && !mcu_req) begin
        mcu_ack <= 1'b0;
      end
    end
  end

  // Request fields held for the whole MCU phase
  always_ff @(posedge CLK2) begin
    if (grant) begin
      write_q <= mcu_write;
      addr_q  <= mcu_addr;
      wdata_q <= mcu_wdata;
    end
  end

  assign acc.valid = valid_q;
  assign acc.write = write_q;
  assign acc.addr  = addr_q;
  assign acc.wdata = wdata_q;

  assign mcu_rdata = acc.rdata;

  ////////////////////
  // Checks
  ////////////////////

  // Request may not be withdrawn while being served
  a_req_held : assert property (
    @(posedge CLK2) disable iff (reset)
    valid_q |=> mcu_req
  ) else $error("mcu_req dropped before mcu_ack");

endmodule

// ==== source/snes_addr_map.sv ====
`timescale 1ns/1ps
`include "snes_mem_consts.svh"

module snes_addr_map (
  input  logic                      CLK2,
  input  logic                      reset,
  input  logic                      cycle_start,
  input  logic                      snes_write,
  input  snes_mem_pkg::snes_addr_u  snes_addr,
  input  snes_mem_pkg::mapper_e     mapper,
  input  snes_mem_pkg::mem_addr_t   rom_mask,
  input  snes_mem_pkg::mem_addr_t   saveram_mask,
  mem_access_if.initiator           acc,
  input  snes_mem_pkg::byte_t       snes_wdata,
  output snes_mem_pkg::byte_t       snes_rdata,
  output logic                      snes_data_drive,
  input  snes_mem_pkg::slot_t       slot
);

  logic                    hit_rom;
  logic                    hit_saveram;
  snes_mem_pkg::mem_addr_t map_addr;

  logic                    rom_q;
  logic                    saveram_q;
  logic                    write_q;
  snes_mem_pkg::mem_addr_t addr_q;
  snes_mem_pkg::byte_t     wdata_q;

  ////////////////////
  // Address decode
  ////////////////////

  always_comb begin
    hit_rom     = 1'b0;
    hit_saveram = 1'b0;
    map_addr    = '0;
    case (mapper)
      snes_mem_pkg::hirom: begin
        // Banks 20-3F and A0-BF, offset 6000-7FFF
        if (snes_addr.hi.bank[6:5] == 2'b01 && snes_addr.hi.offset[15:13] == 3'b011) begin
          hit_saveram = 1'b1;
          map_addr    = `SAVERAM_BASE
                      + ({6'd0, snes_addr.hi.bank[4:0], snes_addr.hi.offset[12:0]}
                         & saveram_mask);
        end else if (snes_addr.hi.bank[6] || snes_addr.hi.offset[15]) begin
          hit_rom  = 1'b1;
          map_addr = {snes_addr.hi.bank, snes_addr.hi.offset} & rom_mask;
        end
      end
      snes_mem_pkg::lorom: begin
        // Banks 70-7F and F0-FF, lower half
        if (snes_addr.lo.bank[6:4] == 3'b111 && !snes_addr.lo.a15) begin
          hit_saveram = 1'b1;
          map_addr    = `SAVERAM_BASE
                      + ({5'd0, snes_addr.lo.bank[3:0], snes_addr.lo.low} & saveram_mask);
        end else if (snes_addr.lo.a15) begin
          hit_rom  = 1'b1;
          map_addr = {2'd0, snes_addr.lo.bank[6:0], snes_addr.lo.low} & rom_mask;
        end
      end
      default: begin
      end
    endcase
  end

  ////////////////////
  // Per-cycle request
  ////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rom_q     <= 1'b0;
      saveram_q <= 1'b0;
      write_q   <= 1'b0;
    end else if (cycle_start) begin
      rom_q     <= hit_rom;
      saveram_q <= hit_saveram;
      write_q   <= snes_write;
    end
  end

  always_ff @(posedge CLK2) begin
    if (cycle_start) begin
      addr_q <= map_addr;
    end
    // Bus data settles late, take it as slot 3 begins
    if (slot == snes_mem_pkg::slot_t'(`SNES_WDATA_SLOT - 1)) begin
      wdata_q <= snes_wdata;
    end
  end

  // ROM is read only, save RAM takes both directions
  assign acc.valid = (rom_q & ~write_q) | saveram_q;
  assign acc.write = write_q;
  assign acc.addr  = addr_q;
  assign acc.wdata = wdata_q;

  assign snes_rdata      = acc.rdata;
  assign snes_data_drive = (rom_q | saveram_q) & ~write_q
                         & (slot <= snes_mem_pkg::slot_t'(`SNES_LAST_SLOT));

endmodule

// ==== source/slot_sequencer.sv ====
`timescale 1ns/1ps
`include "snes_mem_consts.svh"

module slot_sequencer (
  input  logic                CLK2,
  input  logic                reset,
  input  logic                cycle_start,
  output snes_mem_pkg::slot_t slot
);

  always_ff @(posedge CLK2) begin
    if (reset) begin
      slot <= snes_mem_pkg::slot_t'(`SLOT_IDLE);
    end else if (cycle_start) begin
      slot <= '0;
    end else if (slot == snes_mem_pkg::slot_t'(`SLOT_LAST)) begin
      slot <= snes_mem_pkg::slot_t'(`SLOT_IDLE);
    end else if (slot != snes_mem_pkg::slot_t'(`SLOT_IDLE)) begin
      slot <= slot + 1'b1;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // CPU clock too fast if a new cycle cuts the sequence short
  a_start_in_idle : assert property (
    @(posedge CLK2) disable iff (reset)
    cycle_start |-> (slot == snes_mem_pkg::slot_t'(`SLOT_IDLE))
  ) else $error("cycle_start while slot sequence still running");

endmodule

// ==== source/snes_bus_sync.sv ====
`timescale 1ns/1ps
`include "snes_mem_consts.svh"

module snes_bus_sync (
  input  logic CLK2,
  input  logic reset,
  input  logic snes_cpu_clk,
  input  logic snes_rd_n,
  input  logic snes_wr_n,
  output logic cycle_start,
  output logic snes_write
);

  logic [`SYNC_STAGES-1:0] clk_sync;
  logic [`SYNC_STAGES-1:0] rd_sync;
  logic [`SYNC_STAGES-1:0] wr_sync;
  logic                    clk_prev;
  logic                    clk_rise;

  // Rising CPU clock seen at the end of the sync chain
  assign clk_rise = clk_sync[`SYNC_STAGES-1] & ~clk_prev;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      clk_sync    <= '0;
      rd_sync     <= '1;
      wr_sync     <= '1;
      clk_prev    <= 1'b0;
      cycle_start <= 1'b0;
      snes_write  <= 1'b0;
    end else begin
      clk_sync    <= {clk_sync[`SYNC_STAGES-2:0], snes_cpu_clk};
      rd_sync     <= {rd_sync[`SYNC_STAGES-2:0], snes_rd_n};
      wr_sync     <= {wr_sync[`SYNC_STAGES-2:0], snes_wr_n};
      clk_prev    <= clk_sync[`SYNC_STAGES-1];
      cycle_start <= clk_rise;
      // Write cycle when /WR is low and /RD is idle
      if (clk_rise) begin
        snes_write <= ~wr_sync[`SYNC_STAGES-1] & rd_sync[`SYNC_STAGES-1];
      end
    end
  end

endmodule

// ==== source/mem_access_if.sv ====
`timescale 1ns/1ps

// One PSRAM access request plus its read data
interface mem_access_if;

  snes_mem_pkg::mem_addr_t addr;
  snes_mem_pkg::byte_t     wdata;
  logic                    write;
  logic                    valid;
  snes_mem_pkg::byte_t     rdata;

  modport initiator (
    output addr,
    output wdata,
    output write,
    output valid,
    input  rdata
  );

  modport target (
    input  addr,
    input  wdata,
    input  write,
    input  valid,
    output rdata
  );

endinterface

// ==== source/snes_mem_pkg.sv ====
package snes_mem_pkg;

  // Slot index, 0 to 12 active and 13 idle
  typedef logic [3:0] slot_t;

  typedef logic [7:0] byte_t;

  // PSRAM byte address, bit 0 picks the lane
  typedef logic [23:0] mem_addr_t;

  typedef enum logic [1:0] {
    hirom = 2'd0,
    lorom = 2'd1
  } mapper_e;

  ////////////////////
  // SNES address views
  ////////////////////

  // HiROM splits the bus into bank and 16-bit offset
  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset;
  } hirom_view_t;

  // LoROM uses A15 as ROM select within each bank
  typedef struct packed {
    logic [7:0]  bank;
    logic        a15;
    logic [14:0] low;
  } lorom_view_t;

  typedef union packed {
    hirom_view_t hi;
    lorom_view_t lo;
  } snes_addr_u;

endpackage

// ==== include/snes_mem_consts.svh ====
`ifndef SNES_MEM_CONSTS_SVH
`define SNES_MEM_CONSTS_SVH

////////////////////
// Slot boundaries
////////////////////

// Last active slot, the sequencer parks at idle after it
`define SLOT_LAST 12
`define SLOT_IDLE 13

// SNES phase covers slots 0 to 5
`define SNES_LAST_SLOT 5
`define SNES_WDATA_SLOT 3
`define SNES_CAPTURE_SLOT 4

// MCU phase covers slots 6 to 12
`define MCU_FIRST_SLOT 6
`define MCU_CAPTURE_SLOT 12

////////////////////
// Misc
////////////////////

// Flops per asynchronous SNES input
`define SYNC_STAGES 2

// Save RAM sits at the top of the PSRAM
`define SAVERAM_BASE 24'hE00000

`endif
